/* alu.sv */
`timescale 1ns/1ps
`include "cpu8_settings.svh"

module alu (
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    input  cpu8Pkg::aluFunT fun,
    output logic [`DATA_WIDTH-1:0] result,
    output logic zero
);
    import cpu8Pkg::*;

    always_comb begin
        case (fun)
            ALU_PASSA: begin
                result = a;
            end
            ALU_PASSB: begin
                result = b;
            end
            ALU_NOT: begin
                result = ~a;
            end
            ALU_ADD: begin
                result = a + b; // Carry dropped
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_INC: begin
                result = a + 1'b1;
            end
            ALU_DEC: begin
                result = a - 1'b1;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_LSL: begin
                result = a << 1;
            end
            ALU_LSR: begin
                result = a >> 1; // Zero fill
            end
            default: begin
                result = a;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

/* controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    input  logic clock,
    input  logic rstN,
    ctrlBus.controller bus,
    output logic memWrite
);
    import cpu8Pkg::*;

    logic [1:0] step;
    opcodeT opcode;
    regCodeT dstField;
    regCodeT src1Field;
    regCodeT src2Field;
    regCodeT regSelCode;
    logic directMode;

    function automatic aluFunT aluFunFor(opcodeT op);
        case (op)
            OP_AND:  return ALU_AND;
            OP_OR:   return ALU_OR;
            OP_NOT:  return ALU_NOT;
            OP_ADD:  return ALU_ADD;
            OP_SUB:  return ALU_SUB;
            OP_LSR:  return ALU_LSR;
            OP_LSL:  return ALU_LSL;
            OP_INC:  return ALU_INC;
            OP_DEC:  return ALU_DEC;
            default: return ALU_PASSA; // MOV
        endcase
    endfunction

    assign opcode = opcodeT'(bus.instr[15:12]);
    assign dstField = regCodeT'(bus.instr[11:8]);
    assign src1Field = regCodeT'(bus.instr[7:4]);
    assign src2Field = regCodeT'(bus.instr[3:0]);
    assign directMode = bus.instr[10];
    assign regSelCode = regCodeT'({2'b00, bus.instr[9:8]}); // Always R1-R4

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            step <= 2'd0;
        end else begin
            step <= step + 2'd1; // Free running, wraps after T3
        end
    end

    always_comb begin
        bus.irLoadLow = 1'b0;
        bus.irLoadHigh = 1'b0;
        bus.pcIncrement = 1'b0;
        bus.useArAddress = 1'b0;
        bus.arLoadAddress = 1'b0;
        bus.srcA = REG_R1;
        bus.srcB = REG_R1; // General code keeps address port B on PC/AR
        bus.aluFun = ALU_PASSA;
        bus.resultSrc = RES_ALU;
        bus.dstCode = REG_R1;
        bus.dstWrite = 1'b0;
        bus.flagWrite = 1'b0;
        memWrite = 1'b0;

        case (step)
            2'd0: begin // Fetch low byte
                bus.irLoadLow = 1'b1;
                bus.pcIncrement = 1'b1;
            end
            2'd1: begin // Fetch high byte
                bus.irLoadHigh = 1'b1;
                bus.pcIncrement = 1'b1;
            end
            2'd2: begin
                case (opcode)
                    OP_AND, OP_OR, OP_NOT, OP_ADD, OP_SUB, OP_LSR, OP_LSL,
                    OP_INC, OP_DEC, OP_MOV: begin
                        bus.srcA = src1Field;
                        bus.srcB = src2Field;
                        bus.aluFun = aluFunFor(opcode);
                        bus.dstCode = dstField;
                        bus.dstWrite = 1'b1;
                        bus.flagWrite = 1'b1;
                    end
                    OP_BRA: begin
                        bus.resultSrc = RES_IMM;
                        bus.dstCode = REG_PC;
                        bus.dstWrite = 1'b1;
                    end
                    OP_BNE: begin
                        bus.resultSrc = RES_IMM;
                        bus.dstCode = REG_PC;
                        bus.dstWrite = !bus.zero; // Taken on flag clear
                    end
                    OP_LD: begin
                        bus.arLoadAddress = directMode;
                    end
                    OP_ST: begin
                        bus.arLoadAddress = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            default: begin // T3
                case (opcode)
                    OP_LD: begin
                        bus.useArAddress = directMode;
                        bus.resultSrc = directMode ? RES_MEM : RES_IMM;
                        bus.dstCode = regSelCode;
                        bus.dstWrite = 1'b1;
                    end
                    OP_ST: begin
                        bus.useArAddress = 1'b1;
                        bus.srcB = regSelCode;
                        bus.aluFun = ALU_PASSB; // Register onto write data
                        memWrite = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        endcase
    end

endmodule

/* cpu8.f */
+incdir+.
cpu8Pkg.sv
ctrlBus.sv
registerBank.sv
alu.sv
controlUnit.sv
datapath.sv
cpuTop.sv
cpu8_chk.sv
cpu8_tb.sv

/* cpu8Pkg.sv */
package cpu8Pkg;

    typedef enum logic [3:0] {
        OP_AND  = 4'h0,
        OP_OR   = 4'h1,
        OP_NOT  = 4'h2,
        OP_ADD  = 4'h3,
        OP_SUB  = 4'h4,
        OP_LSR  = 4'h5,
        OP_LSL  = 4'h6,
        OP_INC  = 4'h7,
        OP_DEC  = 4'h8,
        OP_BRA  = 4'h9,
        OP_BNE  = 4'hA,
        OP_MOV  = 4'hB,
        OP_LD   = 4'hC,
        OP_ST   = 4'hD,
        OP_PULL = 4'hE, // Reserved, executes as no-op
        OP_PUSH = 4'hF  // Reserved, executes as no-op
    } opcodeT;

    typedef enum logic [3:0] {
        ALU_PASSA,
        ALU_PASSB,
        ALU_NOT,
        ALU_ADD,
        ALU_SUB,
        ALU_INC,
        ALU_DEC,
        ALU_AND,
        ALU_OR,
        ALU_LSL,
        ALU_LSR
    } aluFunT;

    // Bit 2 clear selects the general bank
    typedef enum logic [3:0] {
        REG_R1 = 4'd0,
        REG_R2 = 4'd1,
        REG_R3 = 4'd2,
        REG_R4 = 4'd3,
        REG_SP = 4'd4,
        REG_AR = 4'd5,
        REG_PC = 4'd6,
        REG_PC_ALT = 4'd7
    } regCodeT;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_IMM, // Instruction low byte
        RES_MEM
    } resultSrcT;

endpackage

/* cpu8_chk.sv */
`timescale 1ns/1ps

module cpu8Chk (
    input  logic clock,
    input  logic rstN,
    input  logic [1:0] step,
    input  logic memWrite,
    input  logic pcIncrement,
    input  logic [25:0] ctrlWord // Whole control word plus memWrite
);
    int failCount = 0;

    aWriteOnlyInT3: assert property (
        @(posedge clock) disable iff (!rstN) memWrite |-> step == 2'd3
    ) else begin
        failCount++;
        $error("memWrite high outside T3, step %0d", step);
    end

    aIncrementOnlyInFetch: assert property (
        @(posedge clock) disable iff (!rstN) pcIncrement |-> step inside {2'd0, 2'd1}
    ) else begin
        failCount++;
        $error("pcIncrement high outside T0 and T1, step %0d", step);
    end

    aControlKnown: assert property (
        @(posedge clock) disable iff (!rstN) !$isunknown(ctrlWord)
    ) else begin
        failCount++;
        $error("Control output unknown: %b", ctrlWord);
    end

endmodule

bind controlUnit cpu8Chk uChk (
    .clock(clock),
    .rstN(rstN),
    .step(step),
    .memWrite(memWrite),
    .pcIncrement(bus.pcIncrement),
    .ctrlWord({bus.irLoadLow, bus.irLoadHigh, bus.pcIncrement, bus.useArAddress,
               bus.arLoadAddress, bus.srcA, bus.srcB, bus.aluFun, bus.resultSrc,
               bus.dstCode, bus.dstWrite, bus.flagWrite, memWrite})
);

/* cpu8_settings.svh */
`ifndef CPU8_SETTINGS_SVH
`define CPU8_SETTINGS_SVH

// Datapath and memory byte width
`define DATA_WIDTH 8

// Two bytes per instruction, fetched low byte first
`define INSTR_WIDTH 16

// R1-R4
`define GP_REG_COUNT 4

// SP, AR and PC, in that index order
`define ADDR_REG_COUNT 3

`endif

/* cpu8_tb.sv */
`timescale 1ns/1ps
`include "cpu8_settings.svh"

module cpu8_tb;
    import cpu8Pkg::*;

    localparam int numInstrs = 150;
    localparam int progBytes = 200; // Program in 0-199, store area above
    localparam int cycleLimit = 16 + 4 * numInstrs + 100;

    logic clock;
    logic rstN;
    logic [`DATA_WIDTH-1:0] memReadData;
    logic [`DATA_WIDTH-1:0] memAddress;
    logic [`DATA_WIDTH-1:0] memWriteData;
    logic memWrite;

    logic [7:0] mem [256];
    logic [7:0] modelMem [256];
    logic [7:0] modelGp [4];
    logic [7:0] modelSp;
    logic [7:0] modelAr;
    logic [7:0] modelPc;
    logic modelZero;
    int errorCount = 0;
    int cycleCount = 0;
    int executed = 0;

    cpuTop u_dut (
        .clock(clock),
        .rstN(rstN),
        .memReadData(memReadData),
        .memAddress(memAddress),
        .memWriteData(memWriteData),
        .memWrite(memWrite)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] expected);
        if (got !== expected) begin
            errorCount++;
            $display("[ERROR] %s: expected 0x%02h, got 0x%02h at instruction %0d",
                     name, expected, got, executed);
        end
    endtask

    task automatic checkNoStrobe(input int step);
        if (memWrite !== 1'b0) begin
            errorCount++;
            $display("Memory write strobe outside a store, T%0d of instruction %0d", step, executed);
        end
    endtask

    task automatic buildProgram();
        logic [15:0] word;
        int pick;
        for (int a = 0; a < 256; a++) begin
            mem[a] = 8'($urandom);
        end
        for (int a = 0; a < progBytes; a += 2) begin
            pick = $urandom % 20;
            if (a == progBytes - 2) begin
                word = {OP_BRA, 4'h0, 8'h00}; // Wrap back to the start
            end else if (pick < 9) begin
                word = {4'(pick), 4'($urandom % 6), 4'($urandom % 8), 4'($urandom % 8)};
            end else if (pick < 11) begin
                word = {OP_MOV, 4'($urandom % 6), 4'($urandom % 8), 4'($urandom % 8)};
            end else if (pick < 14) begin
                word = {OP_LD, 1'b0, 1'($urandom), 2'($urandom), 8'($urandom)};
            end else if (pick < 17) begin
                word = {OP_ST, 2'b00, 2'($urandom), 8'(200 + $urandom % 56)};
            end else if (pick < 19) begin
                word = {OP_BNE, 4'h0, 8'(2 * ($urandom % (progBytes / 2)))};
            end else begin
                // Forward only, so loops come from BNE
                word = {OP_BRA, 4'h0, 8'(a + 2 + 2 * ($urandom % ((progBytes - 2 - a) / 2)))};
            end
            mem[a] = word[7:0];
            mem[a + 1] = word[15:8];
        end
        modelMem = mem;
    endtask

    function automatic logic [7:0] readModelReg(input logic [3:0] code);
        case (code)
            4'd0, 4'd1, 4'd2, 4'd3: return modelGp[code[1:0]];
            4'd4: return modelSp;
            4'd5: return modelAr;
            default: return modelPc; // Codes 6 and 7
        endcase
    endfunction

    task automatic writeModelReg(input logic [3:0] code, input logic [7:0] value);
        case (code)
            4'd0, 4'd1, 4'd2, 4'd3: modelGp[code[1:0]] = value;
            4'd4: modelSp = value;
            4'd5: modelAr = value;
            default: modelPc = value;
        endcase
    endtask

    task automatic executeModel(input logic [15:0] word);
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] res;
        logic [7:0] field;
        logic isAluOp;
        a = readModelReg(word[7:4]);
        b = readModelReg(word[3:0]);
        field = word[7:0];
        isAluOp = 1'b1;
        res = 8'h00;
        case (word[15:12])
            OP_AND: res = a & b;
            OP_OR:  res = a | b;
            OP_NOT: res = ~a;
            OP_ADD: res = a + b;
            OP_SUB: res = a - b;
            OP_LSR: res = a >> 1;
            OP_LSL: res = a << 1;
            OP_INC: res = a + 8'd1;
            OP_DEC: res = a - 8'd1;
            OP_MOV: res = a;
            default: isAluOp = 1'b0;
        endcase
        if (isAluOp) begin
            writeModelReg(word[11:8], res);
            modelZero = (res == 8'h00);
        end else if (word[15:12] == OP_LD && word[10]) begin
            modelAr = field;
            writeModelReg({2'b00, word[9:8]}, modelMem[field]);
        end else if (word[15:12] == OP_LD) begin
            writeModelReg({2'b00, word[9:8]}, field); // Immediate
        end else if (word[15:12] == OP_ST) begin
            modelAr = field;
            modelMem[field] = modelGp[word[9:8]];
        end else if (word[15:12] == OP_BRA || (word[15:12] == OP_BNE && !modelZero)) begin
            modelPc = field;
        end
    endtask

    initial begin
        logic [15:0] word;
        logic [7:0] field;
        logic pendingWrite;
        logic [7:0] pendingAddress;
        logic [7:0] pendingData;
        rstN = 1'b0;
        memReadData = '0;
        void'($urandom(46));
        buildProgram();
        foreach (modelGp[i]) begin
            modelGp[i] = 8'h00;
        end
        modelSp = 8'h00;
        modelAr = 8'h00;
        modelPc = 8'h00;
        modelZero = 1'b0;
        pendingWrite = 1'b0;
        repeat (16) @(posedge clock);
        rstN <= 1'b1;
        memReadData <= mem[modelPc];
        for (executed = 0; executed < numInstrs; executed++) begin
            @(negedge clock); // T0
            checkByte("memAddress", memAddress, modelPc);
            checkNoStrobe(0);
            @(posedge clock);
            memReadData <= mem[8'(modelPc + 1)];
            @(negedge clock); // T1
            checkByte("memAddress", memAddress, 8'(modelPc + 1));
            checkNoStrobe(1);
            @(posedge clock);
            word = {modelMem[8'(modelPc + 1)], modelMem[modelPc]};
            field = word[7:0];
            modelPc = modelPc + 8'd2;
            @(negedge clock); // T2
            checkNoStrobe(2);
            @(posedge clock);
            if (word[15:12] == OP_LD && word[10]) begin
                memReadData <= mem[field];
            end
            @(negedge clock); // T3
            if (word[15:12] == OP_ST) begin
                if (memWrite !== 1'b1) begin
                    errorCount++;
                    $display("Store at instruction %0d raised no write strobe in T3", executed);
                end
                checkByte("memAddress", memAddress, field);
                checkByte("memWriteData", memWriteData, modelGp[word[9:8]]);
                pendingWrite = (memWrite === 1'b1);
                pendingAddress = memAddress;
                pendingData = memWriteData;
            end else begin
                if (word[15:12] == OP_LD && word[10]) begin
                    checkByte("memAddress", memAddress, field); // Direct load reads via AR
                end
                checkNoStrobe(3);
            end
            @(posedge clock);
            if (pendingWrite) begin
                mem[pendingAddress] = pendingData;
            end
            pendingWrite = 1'b0;
            executeModel(word);
            memReadData <= mem[modelPc];
        end
        errorCount += u_dut.uControl.uChk.failCount;
        $display("Run complete: %0d instructions, %0d errors", numInstrs, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("Program did not complete within %0d cycles", cycleLimit);
        $display("Run stopped: %0d errors", errorCount);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* cpuTop.sv */
`timescale 1ns/1ps
`include "cpu8_settings.svh"

module cpuTop (
    input  logic clock,
    input  logic rstN,
    input  logic [`DATA_WIDTH-1:0] memReadData,
    output logic [`DATA_WIDTH-1:0] memAddress,
    output logic [`DATA_WIDTH-1:0] memWriteData,
    output logic memWrite
);

    ctrlBus bus ();

    controlUnit uControl (
        .clock(clock),
        .rstN(rstN),
        .bus(bus.controller),
        .memWrite(memWrite)
    );

    datapath uDatapath (
        .clock(clock),
        .rstN(rstN),
        .bus(bus.datapath),
        .memReadData(memReadData),
        .memAddress(memAddress),
        .memWriteData(memWriteData)
    );

endmodule

/* ctrlBus.sv */
`timescale 1ns/1ps
`include "cpu8_settings.svh"

interface ctrlBus;
    import cpu8Pkg::*;

    logic irLoadLow;
    logic irLoadHigh;
    logic pcIncrement;
    logic useArAddress;
    logic arLoadAddress;
    regCodeT srcA;
    regCodeT srcB;
    aluFunT aluFun;
    resultSrcT resultSrc;
    regCodeT dstCode;
    logic dstWrite;
    logic flagWrite;

    logic [`INSTR_WIDTH-1:0] instr; // Feedback for decode
    logic zero;

    modport controller (
        output irLoadLow, irLoadHigh, pcIncrement, useArAddress, arLoadAddress,
        output srcA, srcB, aluFun, resultSrc, dstCode, dstWrite, flagWrite,
        input  instr, zero
    );

    modport datapath (
        input  irLoadLow, irLoadHigh, pcIncrement, useArAddress, arLoadAddress,
        input  srcA, srcB, aluFun, resultSrc, dstCode, dstWrite, flagWrite,
        output instr, zero
    );

endinterface

/* datapath.sv */
`timescale 1ns/1ps
`include "cpu8_settings.svh"

module datapath (
    input  logic clock,
    input  logic rstN,
    ctrlBus.datapath bus,
    input  logic [`DATA_WIDTH-1:0] memReadData,
    output logic [`DATA_WIDTH-1:0] memAddress,
    output logic [`DATA_WIDTH-1:0] memWriteData
);
    import cpu8Pkg::*;

    localparam int gpIdxW = $clog2(`GP_REG_COUNT);
    localparam int addrIdxW = $clog2(`ADDR_REG_COUNT);
    localparam int arIndex = 1;
    localparam int pcIndex = 2;

    logic [`INSTR_WIDTH-1:0] instrReg;
    logic zeroFlag;
    logic [`DATA_WIDTH-1:0] gpReadA, gpReadB;
    logic [`DATA_WIDTH-1:0] addrReadA, addrReadB;
    logic [`DATA_WIDTH-1:0] aluA, aluB, aluResult;
    logic aluZero;
    logic [`DATA_WIDTH-1:0] writeData;
    logic gpWrite, addrWrite;
    logic [addrIdxW-1:0] addrWriteIndex, addrReadIndexB;
    logic [`DATA_WIDTH-1:0] addrWriteData;

    function automatic logic isGeneral(regCodeT code);
        return !code[2];
    endfunction

    function automatic logic [gpIdxW-1:0] gpIndex(regCodeT code);
        return gpIdxW'(code[1:0]);
    endfunction

    // SP, AR, PC; code 7 aliases PC
    function automatic logic [addrIdxW-1:0] addrIndex(regCodeT code);
        return (code[1:0] == 2'd3) ? addrIdxW'(pcIndex) : addrIdxW'(code[1:0]);
    endfunction

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            instrReg <= '0;
            zeroFlag <= 1'b0;
        end else begin
            if (bus.irLoadLow) begin
                instrReg[7:0] <= memReadData;
            end
            if (bus.irLoadHigh) begin
                instrReg[15:8] <= memReadData;
            end
            if (bus.flagWrite) begin
                zeroFlag <= aluZero;
            end
        end
    end

    assign bus.instr = instrReg;
    assign bus.zero = zeroFlag;

    always_comb begin
        case (bus.resultSrc)
            RES_IMM: writeData = instrReg[7:0];
            RES_MEM: writeData = memReadData;
            default: writeData = aluResult;
        endcase
    end

    assign gpWrite = bus.dstWrite && isGeneral(bus.dstCode);
    assign addrWrite = bus.arLoadAddress || (bus.dstWrite && !isGeneral(bus.dstCode));
    assign addrWriteIndex = bus.arLoadAddress ? addrIdxW'(arIndex) : addrIndex(bus.dstCode);
    assign addrWriteData = bus.arLoadAddress ? instrReg[7:0] : writeData;

    // Port B also serves the memory address while srcB is a general code
    assign addrReadIndexB = !isGeneral(bus.srcB) ? addrIndex(bus.srcB) :
                            bus.useArAddress ? addrIdxW'(arIndex) : addrIdxW'(pcIndex);

    registerBank #(.regCount(`GP_REG_COUNT), .incrementIndex(`GP_REG_COUNT)) uGpBank (
        .clock(clock), .rstN(rstN),
        .writeIndex(gpIndex(bus.dstCode)), .write(gpWrite), .writeData(writeData),
        .increment(1'b0),
        .readIndexA(gpIndex(bus.srcA)), .readIndexB(gpIndex(bus.srcB)),
        .readDataA(gpReadA), .readDataB(gpReadB)
    );

    registerBank #(.regCount(`ADDR_REG_COUNT), .incrementIndex(pcIndex)) uAddrBank (
        .clock(clock), .rstN(rstN),
        .writeIndex(addrWriteIndex), .write(addrWrite), .writeData(addrWriteData),
        .increment(bus.pcIncrement),
        .readIndexA(addrIndex(bus.srcA)), .readIndexB(addrReadIndexB),
        .readDataA(addrReadA), .readDataB(addrReadB)
    );

    assign aluA = isGeneral(bus.srcA) ? gpReadA : addrReadA;
    assign aluB = isGeneral(bus.srcB) ? gpReadB : addrReadB;

    alu uAlu (.a(aluA), .b(aluB), .fun(bus.aluFun), .result(aluResult), .zero(aluZero));

    assign memAddress = addrReadB;
    assign memWriteData = aluResult;

endmodule

/* registerBank.sv */
`timescale 1ns/1ps
`include "cpu8_settings.svh"

module registerBank #(
    parameter int unsigned regCount = 4,
    parameter int unsigned incrementIndex = 4
) (
    input  logic clock,
    input  logic rstN,
    input  logic [$clog2(regCount)-1:0] writeIndex,
    input  logic write,
    input  logic [`DATA_WIDTH-1:0] writeData,
    input  logic increment,
    input  logic [$clog2(regCount)-1:0] readIndexA,
    input  logic [$clog2(regCount)-1:0] readIndexB,
    output logic [`DATA_WIDTH-1:0] readDataA,
    output logic [`DATA_WIDTH-1:0] readDataB
);
    localparam int idxW = $clog2(regCount);

    logic [`DATA_WIDTH-1:0] regs [regCount];

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < regCount; i++) begin
                if (write && writeIndex == idxW'(i)) begin
                    regs[i] <= writeData; // Load wins over count
                end else if (increment && i == incrementIndex) begin
                    regs[i] <= regs[i] + 1'b1;
                end
            end
        end
    end

    // Unpopulated indices read as zero
    assign readDataA = (readIndexA < regCount) ? regs[readIndexA] : '0;
    assign readDataB = (readIndexB < regCount) ? regs[readIndexB] : '0;

endmodule
